//--- hw/axi_lite_pkg.sv
package axi_lite_pkg;

  // AXI response codes
  // Every address maps to the chip, so only OKAY is returned
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } resp_e;

  // Slave transaction states
  // One operation runs at a time on the single-port SRAM
  typedef enum logic [2:0] {
    IDLE,
    WRITE_ACCESS,
    WRITE_RESP,
    READ_ACCESS,
    READ_RESP
  } xact_e;

endpackage

//--- hw/sram_pkg.sv
package sram_pkg;

  // Phases of one SRAM operation
  typedef enum logic [1:0] {
    IDLE,
    SETUP,
    ACCESS,
    DONE
  } phase_e;

  // Cycles the strobe is held low
  localparam int DEFAULT_ACCESS_CYCLES = 2;

endpackage

//--- hw/sram_phy_ctrl.sv
`timescale 1ns/1ps

module sram_phy_ctrl #(
  parameter int ADDR_WIDTH    = 20,
  parameter int DATA_WIDTH    = 16,
  parameter int ACCESS_CYCLES = 2
) (
  input  logic                    axi_aclk,
  input  logic                    axi_aresetn,
  input  logic                    req,
  input  logic                    write_enable,
  input  logic [ADDR_WIDTH-1:0]   addr,
  input  logic [DATA_WIDTH-1:0]   write_data,
  input  logic [DATA_WIDTH/8-1:0] byte_en,
  output logic                    ready,
  output logic [DATA_WIDTH-1:0]   read_data,
  output logic [ADDR_WIDTH-1:0]   sram_addr,
  output logic                    sram_we_n,
  output logic                    sram_oe_n,
  output logic                    sram_ce_n,
  output logic [DATA_WIDTH/8-1:0] sram_be_n,
  inout  wire  [DATA_WIDTH-1:0]   sram_data
);

  localparam int CNT_WIDTH = (ACCESS_CYCLES > 1) ? $clog2(ACCESS_CYCLES) : 1;

  sram_pkg::phase_e state_q, state_d;
  logic [CNT_WIDTH-1:0] cnt_q;
  logic [ADDR_WIDTH-1:0] addr_q;
  logic [DATA_WIDTH-1:0] wdata_q;
  logic wr_q;
  logic drive_en;
  logic last_access;

  assign last_access = (state_q == sram_pkg::ACCESS) && (cnt_q == '0);

  always_comb begin
    state_d = state_q;
    case (state_q)
      sram_pkg::IDLE:   if (req) state_d = sram_pkg::SETUP;
      sram_pkg::SETUP:  state_d = sram_pkg::ACCESS;
      sram_pkg::ACCESS: if (cnt_q == '0) state_d = sram_pkg::DONE;
      default:          state_d = sram_pkg::IDLE;
    endcase
  end

  // Phase, counter and registered pin strobes
  always_ff @(posedge axi_aclk or negedge axi_aresetn) begin
    if (!axi_aresetn) begin
      state_q   <= sram_pkg::IDLE;
      cnt_q     <= '0;
      sram_ce_n <= 1'b1;
      sram_oe_n <= 1'b1;
      sram_we_n <= 1'b1;
      sram_be_n <= '1;
    end else begin
      state_q   <= state_d;
      if (state_q == sram_pkg::SETUP) begin
        cnt_q <= CNT_WIDTH'(ACCESS_CYCLES - 1);
      end else if (state_q == sram_pkg::ACCESS) begin
        cnt_q <= cnt_q - 1'b1;
      end
      sram_ce_n <= (state_d == sram_pkg::IDLE);
      sram_oe_n <= !((state_d == sram_pkg::ACCESS) && !wr_q);
      sram_we_n <= !((state_d == sram_pkg::ACCESS) && wr_q);
      // Lanes follow chip enable from SETUP through DONE
      if ((state_q == sram_pkg::IDLE) && req) begin
        sram_be_n <= ~byte_en;
      end else if (state_d == sram_pkg::IDLE) begin
        sram_be_n <= '1;
      end
    end
  end

  // Operation payload, taken when the request is accepted
  always_ff @(posedge axi_aclk) begin
    if ((state_q == sram_pkg::IDLE) && req) begin
      addr_q  <= addr;
      wdata_q <= write_data;
      wr_q    <= write_enable;
    end
    if (last_access && !wr_q) begin
      read_data <= sram_data;
    end
  end

  // Bus driven through the write access cycles
  assign drive_en  = (state_q == sram_pkg::ACCESS) && wr_q;

  assign ready     = (state_q == sram_pkg::DONE);
  assign sram_addr = addr_q;
  assign sram_data = drive_en ? wdata_q : {DATA_WIDTH{1'bz}};

endmodule

//--- hw/axi_sram_slave.sv
`timescale 1ns/1ps

module axi_sram_slave #(
  parameter int ADDR_WIDTH = 20,
  parameter int DATA_WIDTH = 16
) (
  input  logic                    axi_aclk,
  input  logic                    axi_aresetn,
  input  logic [ADDR_WIDTH-1:0]   s_axi_awaddr,
  input  logic                    s_axi_awvalid,
  output logic                    s_axi_awready,
  input  logic [DATA_WIDTH-1:0]   s_axi_wdata,
  input  logic [DATA_WIDTH/8-1:0] s_axi_wstrb,
  input  logic                    s_axi_wvalid,
  output logic                    s_axi_wready,
  output logic [1:0]              s_axi_bresp,
  output logic                    s_axi_bvalid,
  input  logic                    s_axi_bready,
  input  logic [ADDR_WIDTH-1:0]   s_axi_araddr,
  input  logic                    s_axi_arvalid,
  output logic                    s_axi_arready,
  output logic [DATA_WIDTH-1:0]   s_axi_rdata,
  output logic [1:0]              s_axi_rresp,
  output logic                    s_axi_rvalid,
  input  logic                    s_axi_rready,
  output logic                    req,
  output logic                    write_enable,
  output logic [ADDR_WIDTH-1:0]   addr,
  output logic [DATA_WIDTH-1:0]   write_data,
  output logic [DATA_WIDTH/8-1:0] byte_en,
  input  logic                    ready,
  input  logic [DATA_WIDTH-1:0]   read_data
);

  axi_lite_pkg::xact_e state_q;

  logic [ADDR_WIDTH-1:0] aw_addr_q;
  logic [DATA_WIDTH-1:0] w_data_q;
  logic [DATA_WIDTH/8-1:0] w_strb_q;
  logic [ADDR_WIDTH-1:0] ar_addr_q;
  logic [DATA_WIDTH-1:0] rdata_q;
  logic aw_held, w_held, ar_held;
  logic awready_q, wready_q, arready_q;
  logic last_was_read;
  logic idle, wr_pend, pick_write, pick_read, accept_ok;
  logic aw_hs, w_hs, ar_hs;

  assign idle    = (state_q == axi_lite_pkg::IDLE);
  assign wr_pend = aw_held && w_held;

  // Alternate when both kinds wait; write wins after reset
  assign pick_write = idle && wr_pend && (!ar_held || last_was_read);
  assign pick_read  = idle && ar_held && !pick_write;

  // New channels are only taken while nothing is in flight
  assign accept_ok = idle && !req;

  assign aw_hs = s_axi_awvalid && awready_q;
  assign w_hs  = s_axi_wvalid && wready_q;
  assign ar_hs = s_axi_arvalid && arready_q;

  always_ff @(posedge axi_aclk or negedge axi_aresetn) begin
    if (!axi_aresetn) begin
      awready_q <= 1'b0;
      wready_q  <= 1'b0;
      arready_q <= 1'b0;
      aw_held   <= 1'b0;
      w_held    <= 1'b0;
      ar_held   <= 1'b0;
    end else begin
      // One-cycle ready pulses
      awready_q <= accept_ok && s_axi_awvalid && !aw_held && !awready_q;
      wready_q  <= accept_ok && s_axi_wvalid && !w_held && !wready_q;
      arready_q <= accept_ok && s_axi_arvalid && !ar_held && !arready_q;
      if (aw_hs) begin
        aw_held <= 1'b1;
      end else if (pick_write) begin
        aw_held <= 1'b0;
      end
      if (w_hs) begin
        w_held <= 1'b1;
      end else if (pick_write) begin
        w_held <= 1'b0;
      end
      if (ar_hs) begin
        ar_held <= 1'b1;
      end else if (pick_read) begin
        ar_held <= 1'b0;
      end
    end
  end

  always_ff @(posedge axi_aclk) begin
    if (aw_hs) aw_addr_q <= s_axi_awaddr;
    if (w_hs) begin
      w_data_q <= s_axi_wdata;
      w_strb_q <= s_axi_wstrb;
    end
    if (ar_hs) ar_addr_q <= s_axi_araddr;
    if ((state_q == axi_lite_pkg::READ_ACCESS) && ready) rdata_q <= read_data;
  end

  // Transaction sequencing and last-served tracking
  always_ff @(posedge axi_aclk or negedge axi_aresetn) begin
    if (!axi_aresetn) begin
      state_q       <= axi_lite_pkg::IDLE;
      last_was_read <= 1'b1;
    end else begin
      case (state_q)
        axi_lite_pkg::IDLE: begin
          if (pick_write) begin
            state_q       <= axi_lite_pkg::WRITE_ACCESS;
            last_was_read <= 1'b0;
          end else if (pick_read) begin
            state_q       <= axi_lite_pkg::READ_ACCESS;
            last_was_read <= 1'b1;
          end
        end
        axi_lite_pkg::WRITE_ACCESS: if (ready) state_q <= axi_lite_pkg::WRITE_RESP;
        axi_lite_pkg::WRITE_RESP:   if (s_axi_bready) state_q <= axi_lite_pkg::IDLE;
        axi_lite_pkg::READ_ACCESS:  if (ready) state_q <= axi_lite_pkg::READ_RESP;
        axi_lite_pkg::READ_RESP:    if (s_axi_rready) state_q <= axi_lite_pkg::IDLE;
        default:                    state_q <= axi_lite_pkg::IDLE;
      endcase
    end
  end

  // Request to the pin controller
  assign req          = pick_write || pick_read;
  assign write_enable = pick_write;
  assign addr         = pick_write ? aw_addr_q : ar_addr_q;
  assign write_data   = w_data_q;
  assign byte_en      = pick_write ? w_strb_q : '1;

  assign s_axi_awready = awready_q;
  assign s_axi_wready  = wready_q;
  assign s_axi_arready = arready_q;
  assign s_axi_bvalid  = (state_q == axi_lite_pkg::WRITE_RESP);
  assign s_axi_rvalid  = (state_q == axi_lite_pkg::READ_RESP);
  assign s_axi_bresp   = axi_lite_pkg::RESP_OKAY;
  assign s_axi_rresp   = axi_lite_pkg::RESP_OKAY;
  assign s_axi_rdata   = rdata_q;

endmodule

//--- hw/axi_sram_top.sv
`timescale 1ns/1ps

module axi_sram_top #(
  parameter int ADDR_WIDTH    = 20,
  parameter int DATA_WIDTH    = 16,
  parameter int ACCESS_CYCLES = sram_pkg::DEFAULT_ACCESS_CYCLES
) (
  input  logic                    axi_aclk,
  input  logic                    axi_aresetn,
  input  logic [ADDR_WIDTH-1:0]   s_axi_awaddr,
  input  logic                    s_axi_awvalid,
  output logic                    s_axi_awready,
  input  logic [DATA_WIDTH-1:0]   s_axi_wdata,
  input  logic [DATA_WIDTH/8-1:0] s_axi_wstrb,
  input  logic                    s_axi_wvalid,
  output logic                    s_axi_wready,
  output logic [1:0]              s_axi_bresp,
  output logic                    s_axi_bvalid,
  input  logic                    s_axi_bready,
  input  logic [ADDR_WIDTH-1:0]   s_axi_araddr,
  input  logic                    s_axi_arvalid,
  output logic                    s_axi_arready,
  output logic [DATA_WIDTH-1:0]   s_axi_rdata,
  output logic [1:0]              s_axi_rresp,
  output logic                    s_axi_rvalid,
  input  logic                    s_axi_rready,
  output logic [ADDR_WIDTH-1:0]   sram_addr,
  output logic                    sram_we_n,
  output logic                    sram_oe_n,
  output logic                    sram_ce_n,
  output logic [DATA_WIDTH/8-1:0] sram_be_n,
  inout  wire  [DATA_WIDTH-1:0]   sram_data
);

  // Slave to pin controller request path
  logic                    req;
  logic                    write_enable;
  logic [ADDR_WIDTH-1:0]   mem_addr;
  logic [DATA_WIDTH-1:0]   mem_wdata;
  logic [DATA_WIDTH/8-1:0] mem_be;
  logic                    ready;
  logic [DATA_WIDTH-1:0]   mem_rdata;

  axi_sram_slave #(
    .ADDR_WIDTH(ADDR_WIDTH),
    .DATA_WIDTH(DATA_WIDTH)
  ) slave_i (
    .axi_aclk     (axi_aclk),
    .axi_aresetn  (axi_aresetn),
    .s_axi_awaddr (s_axi_awaddr),
    .s_axi_awvalid(s_axi_awvalid),
    .s_axi_awready(s_axi_awready),
    .s_axi_wdata  (s_axi_wdata),
    .s_axi_wstrb  (s_axi_wstrb),
    .s_axi_wvalid (s_axi_wvalid),
    .s_axi_wready (s_axi_wready),
    .s_axi_bresp  (s_axi_bresp),
    .s_axi_bvalid (s_axi_bvalid),
    .s_axi_bready (s_axi_bready),
    .s_axi_araddr (s_axi_araddr),
    .s_axi_arvalid(s_axi_arvalid),
    .s_axi_arready(s_axi_arready),
    .s_axi_rdata  (s_axi_rdata),
    .s_axi_rresp  (s_axi_rresp),
    .s_axi_rvalid (s_axi_rvalid),
    .s_axi_rready (s_axi_rready),
    .req          (req),
    .write_enable (write_enable),
    .addr         (mem_addr),
    .write_data   (mem_wdata),
    .byte_en      (mem_be),
    .ready        (ready),
    .read_data    (mem_rdata)
  );

  sram_phy_ctrl #(
    .ADDR_WIDTH   (ADDR_WIDTH),
    .DATA_WIDTH   (DATA_WIDTH),
    .ACCESS_CYCLES(ACCESS_CYCLES)
  ) phy_i (
    .axi_aclk    (axi_aclk),
    .axi_aresetn (axi_aresetn),
    .req         (req),
    .write_enable(write_enable),
    .addr        (mem_addr),
    .write_data  (mem_wdata),
    .byte_en     (mem_be),
    .ready       (ready),
    .read_data   (mem_rdata),
    .sram_addr   (sram_addr),
    .sram_we_n   (sram_we_n),
    .sram_oe_n   (sram_oe_n),
    .sram_ce_n   (sram_ce_n),
    .sram_be_n   (sram_be_n),
    .sram_data   (sram_data)
  );

endmodule

//--- dv/async_sram_model.sv
`timescale 1ns/1ps

module async_sram_model #(
  parameter int ADDR_WIDTH = 20,
  parameter int DATA_WIDTH = 16
) (
  input  logic [ADDR_WIDTH-1:0]   sram_addr,
  input  logic                    sram_ce_n,
  input  logic                    sram_oe_n,
  input  logic                    sram_we_n,
  input  logic [DATA_WIDTH/8-1:0] sram_be_n,
  inout  wire  [DATA_WIDTH-1:0]   sram_data
);

  logic [DATA_WIDTH-1:0] mem [0:(1<<ADDR_WIDTH)-1];

  // Power-up contents, a pattern over all address bits
  initial begin
    for (int i = 0; i < (1 << ADDR_WIDTH); i++) begin
      mem[i] = DATA_WIDTH'(i ^ (i >> DATA_WIDTH) ^ 32'h5a5a);
    end
  end

  // Chip drives the bus only for an enabled read
  assign sram_data = (!sram_ce_n && !sram_oe_n && sram_we_n) ? mem[sram_addr]
                                                             : {DATA_WIDTH{1'bz}};

  // Data settles shortly after the write strobe falls
  always @(negedge sram_we_n) begin
    #1;
    if (!sram_ce_n) begin
      for (int b = 0; b < DATA_WIDTH/8; b++) begin
        if (!sram_be_n[b]) mem[sram_addr][b*8 +: 8] = sram_data[b*8 +: 8];
      end
    end
  end

endmodule

//--- dv/axi_sram_properties.sv
`timescale 1ns/1ps

module axi_sram_properties #(
  parameter int DATA_WIDTH    = 16,
  parameter int ACCESS_CYCLES = 2
) (
  input logic                  axi_aclk,
  input logic                  axi_aresetn,
  input logic                  s_axi_awvalid,
  input logic                  s_axi_awready,
  input logic                  s_axi_wvalid,
  input logic                  s_axi_wready,
  input logic                  s_axi_arvalid,
  input logic                  s_axi_arready,
  input logic                  s_axi_bvalid,
  input logic                  s_axi_bready,
  input logic                  s_axi_rvalid,
  input logic                  s_axi_rready,
  input logic [DATA_WIDTH-1:0] s_axi_rdata,
  input logic                  req,
  input logic                  write_enable,
  input logic                  wr_pend,
  input logic                  rd_pend,
  input logic                  dut_drive,
  input logic                  sram_we_n,
  input logic                  sram_oe_n,
  input logic                  sram_ce_n
);

  logic strobe;
  int   low_cnt;
  logic last_req_read;
  int   fail_cnt = 0;

  assign strobe = !sram_we_n || !sram_oe_n;

  always_ff @(posedge axi_aclk or negedge axi_aresetn) begin
    if (!axi_aresetn) begin
      low_cnt       <= 0;
      last_req_read <= 1'b1;
    end else begin
      low_cnt <= strobe ? low_cnt + 1 : 0;
      if (req) last_req_read <= !write_enable;
    end
  end

  no_overlap: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
    !(!sram_we_n && !sram_oe_n))
    else begin
      fail_cnt++;
      $error("write and output enable low together");
    end
  window_len: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
    $fell(strobe) |-> low_cnt == ACCESS_CYCLES)
    else begin
      fail_cnt++;
      $error("strobe window has the wrong length");
    end
  ce_before: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
    $rose(strobe) |-> $past(!sram_ce_n) && $past(sram_ce_n, 2))
    else begin
      fail_cnt++;
      $error("chip enable not low for one cycle before the strobe");
    end
  ce_after: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
    $fell(strobe) |-> !sram_ce_n ##1 sram_ce_n)
    else begin
      fail_cnt++;
      $error("chip enable not low for one cycle after the strobe");
    end
  drive_on_write: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
    dut_drive == !sram_we_n)
    else begin
      fail_cnt++;
      $error("data bus driven outside a write window");
    end
  b_hold: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
    s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid)
    else begin
      fail_cnt++;
      $error("bvalid dropped before bready");
    end
  r_hold: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
    s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid && $stable(s_axi_rdata))
    else begin
      fail_cnt++;
      $error("rvalid or rdata changed before rready");
    end
  no_req_in_resp: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
    (s_axi_bvalid || s_axi_rvalid) |-> !req)
    else begin
      fail_cnt++;
      $error("request issued while a response is pending");
    end
  alternate: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
    req && wr_pend && rd_pend |-> write_enable == last_req_read)
    else begin
      fail_cnt++;
      $error("arbiter did not alternate between write and read");
    end
  read_latency: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
    s_axi_arvalid && s_axi_arready && !wr_pend &&
    !(s_axi_awvalid && s_axi_awready) &&
    !(s_axi_wvalid && s_axi_wready)
    |-> ##(ACCESS_CYCLES+4) s_axi_rvalid)
    else begin
      fail_cnt++;
      $error("read latency differs from the idle value");
    end

endmodule

//--- dv/axi_sram_tb.sv
`timescale 1ns/1ps

module axi_sram_tb;

  localparam int AW     = 20;
  localparam int DW     = 16;
  localparam int AC     = sram_pkg::DEFAULT_ACCESS_CYCLES;
  localparam int N_XACT = 56;

  logic          axi_aclk = 1'b0;
  logic          axi_aresetn = 1'b0;
  logic [AW-1:0] awaddr = '0;
  logic          awvalid = 1'b0;
  logic          awready;
  logic [DW-1:0] wdata = '0;
  logic [1:0]    wstrb = '0;
  logic          wvalid = 1'b0;
  logic          wready;
  logic [1:0]    bresp;
  logic          bvalid;
  logic          bready = 1'b0;
  logic [AW-1:0] araddr = '0;
  logic          arvalid = 1'b0;
  logic          arready;
  logic [DW-1:0] rdata;
  logic [1:0]    rresp;
  logic          rvalid;
  logic          rready = 1'b0;
  logic [AW-1:0] sram_addr;
  logic          sram_we_n, sram_oe_n, sram_ce_n;
  logic [1:0]    sram_be_n;
  wire  [DW-1:0] sram_data;

  logic [DW-1:0] shadow [int unsigned];
  logic [AW-1:0] addr_list [8];
  logic          last_read = 1'b1;

  axi_sram_top #(.ADDR_WIDTH(AW), .DATA_WIDTH(DW), .ACCESS_CYCLES(AC)) dut_i (
    .axi_aclk(axi_aclk), .axi_aresetn(axi_aresetn),
    .s_axi_awaddr(awaddr), .s_axi_awvalid(awvalid), .s_axi_awready(awready),
    .s_axi_wdata(wdata), .s_axi_wstrb(wstrb), .s_axi_wvalid(wvalid),
    .s_axi_wready(wready), .s_axi_bresp(bresp), .s_axi_bvalid(bvalid),
    .s_axi_bready(bready), .s_axi_araddr(araddr), .s_axi_arvalid(arvalid),
    .s_axi_arready(arready), .s_axi_rdata(rdata), .s_axi_rresp(rresp),
    .s_axi_rvalid(rvalid), .s_axi_rready(rready),
    .sram_addr(sram_addr), .sram_we_n(sram_we_n), .sram_oe_n(sram_oe_n),
    .sram_ce_n(sram_ce_n), .sram_be_n(sram_be_n), .sram_data(sram_data)
  );

  async_sram_model #(.ADDR_WIDTH(AW), .DATA_WIDTH(DW)) sram_i (
    .sram_addr(sram_addr), .sram_ce_n(sram_ce_n), .sram_oe_n(sram_oe_n),
    .sram_we_n(sram_we_n), .sram_be_n(sram_be_n), .sram_data(sram_data)
  );

  bind axi_sram_top axi_sram_properties #(
    .DATA_WIDTH(DATA_WIDTH), .ACCESS_CYCLES(ACCESS_CYCLES)
  ) props_i (
    .axi_aclk(axi_aclk), .axi_aresetn(axi_aresetn),
    .s_axi_awvalid(s_axi_awvalid), .s_axi_awready(s_axi_awready),
    .s_axi_wvalid(s_axi_wvalid), .s_axi_wready(s_axi_wready),
    .s_axi_arvalid(s_axi_arvalid), .s_axi_arready(s_axi_arready),
    .s_axi_bvalid(s_axi_bvalid), .s_axi_bready(s_axi_bready),
    .s_axi_rvalid(s_axi_rvalid), .s_axi_rready(s_axi_rready),
    .s_axi_rdata(s_axi_rdata), .req(req), .write_enable(write_enable),
    .wr_pend(slave_i.wr_pend), .rd_pend(slave_i.ar_held), .dut_drive(phy_i.drive_en),
    .sram_we_n(sram_we_n), .sram_oe_n(sram_oe_n), .sram_ce_n(sram_ce_n)
  );

  always #5 axi_aclk = ~axi_aclk;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [DW-1:0] exp,
                             input logic [DW-1:0] act);
    assert (act == exp)
      else fail_run($sformatf("Fail %s expected %h actual %h", name, exp, act));
  endtask

  function automatic logic [DW-1:0] merge_bytes(input logic [DW-1:0] old,
                                                input logic [DW-1:0] data,
                                                input logic [1:0] strb);
    logic [DW-1:0] res;
    res = old;
    if (strb[0]) res[7:0] = data[7:0];
    if (strb[1]) res[15:8] = data[15:8];
    return res;
  endfunction

  task automatic send_aw(input logic [AW-1:0] a);
    awaddr  = a;
    awvalid = 1'b1;
    do @(negedge axi_aclk); while (!awready);
    @(posedge axi_aclk);
    #1 awvalid = 1'b0;
  endtask

  task automatic send_w(input logic [DW-1:0] d, input logic [1:0] s);
    wdata  = d;
    wstrb  = s;
    wvalid = 1'b1;
    do @(negedge axi_aclk); while (!wready);
    @(posedge axi_aclk);
    #1 wvalid = 1'b0;
  endtask

  // Channel order 0 is AW first, 1 is W first, 2 is both at once
  task automatic axi_write(input logic [AW-1:0] a, input logic [DW-1:0] d,
                           input logic [1:0] s, input int order, input string name);
    int unsigned stall;
    stall = $urandom_range(0, 6);
    shadow[a] = merge_bytes(shadow.exists(a) ? shadow[a] : '0, d, s);
    case (order)
      0: begin
        send_aw(a);
        send_w(d, s);
      end
      1: begin
        send_w(d, s);
        send_aw(a);
      end
      default: fork
        send_aw(a);
        send_w(d, s);
      join
    endcase
    do @(negedge axi_aclk); while (!bvalid);
    repeat (stall) @(negedge axi_aclk);
    @(posedge axi_aclk);
    #1 bready = 1'b1;
    @(negedge axi_aclk);
    check_value({name, " bresp"}, '0, DW'(bresp));
    @(posedge axi_aclk);
    #1 bready = 1'b0;
    last_read = 1'b0;
  endtask

  task automatic axi_read(input logic [AW-1:0] a, input logic [DW-1:0] exp,
                          input string name);
    int unsigned stall;
    stall   = $urandom_range(0, 6);
    araddr  = a;
    arvalid = 1'b1;
    do @(negedge axi_aclk); while (!arready);
    @(posedge axi_aclk);
    #1 arvalid = 1'b0;
    do @(negedge axi_aclk); while (!rvalid);
    repeat (stall) @(negedge axi_aclk);
    @(posedge axi_aclk);
    #1 rready = 1'b1;
    @(negedge axi_aclk);
    check_value({name, " rresp"}, '0, DW'(rresp));
    check_value(name, exp, rdata);
    @(posedge axi_aclk);
    #1 rready = 1'b0;
    last_read = 1'b1;
  endtask

  initial begin
    #(N_XACT * (AC + 20) * 10 + 8 * 10);
    fail_run("Watchdog timeout: the tests did not finish in time");
  end

  initial begin
    wait (dut_i.props_i.fail_cnt != 0);
    fail_run("A bound property on the AXI or SRAM pins failed");
  end

  initial begin
    logic [AW-1:0] a;
    logic [DW-1:0] d;
    logic [DW-1:0] exp;
    logic [1:0]    s;
    void'($urandom(32'h97a9a73e));
    repeat (8) @(posedge axi_aclk);
    #1 axi_aresetn = 1'b1;

    // Full-word write then read back
    for (int i = 0; i < 8; i++) begin
      addr_list[i] = AW'($urandom);
      axi_write(addr_list[i], DW'($urandom), 2'b11, 0, "write_read");
    end
    for (int i = 0; i < 8; i++) axi_read(addr_list[i], shadow[addr_list[i]], "write_read");

    // Single byte lanes
    for (int i = 0; i < 4; i++) begin
      axi_write(addr_list[i], DW'($urandom), 2'b01, 0, "byte_low");
      axi_read(addr_list[i], shadow[addr_list[i]], "byte_low");
      axi_write(addr_list[i], DW'($urandom), 2'b10, 0, "byte_high");
      axi_read(addr_list[i], shadow[addr_list[i]], "byte_high");
    end

    // AW first, W first, both together
    for (int order = 0; order < 3; order++) begin
      a = AW'($urandom);
      axi_write(a, DW'($urandom), 2'b11, order, "channel_order");
      axi_read(a, shadow[a], "channel_order");
    end

    // AW, W and AR in one cycle, after a lone read or a lone write
    for (int i = 0; i < 6; i++) begin
      a = addr_list[i];
      if (i % 2 == 0) begin
        axi_read(a, shadow[a], "arbitration");
      end else begin
        axi_write(a, DW'($urandom), 2'b11, 0, "arbitration");
      end
      d   = DW'($urandom);
      s   = 2'($urandom_range(1, 3));
      // The kind not served last goes first
      exp = last_read ? merge_bytes(shadow[a], d, s) : shadow[a];
      fork
        axi_write(a, d, s, 2, "arbitration");
        axi_read(a, exp, "arbitration");
      join
    end

    repeat (4) @(negedge axi_aclk);
    if (dut_i.props_i.fail_cnt == 0) begin
      $display("Verification passed");
      $finish;
    end else begin
      fail_run("A bound property on the AXI or SRAM pins failed");
    end
  end

endmodule

//--- sources.f
hw/axi_lite_pkg.sv
hw/sram_pkg.sv
hw/sram_phy_ctrl.sv
hw/axi_sram_slave.sv
hw/axi_sram_top.sv
dv/async_sram_model.sv
dv/axi_sram_properties.sv
dv/axi_sram_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = axi_sram_tb
FILELIST = sources.f

SOURCES  = $(shell grep -v '^+' $(FILELIST))
BIN      = obj_dir/V$(TOP)
LOG      = sim.log

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Verification passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
